// File: sources.f
+incdir+testbench
hw/aligner_pkg.sv
hw/fetch_queue.sv
hw/align_ctl.sv
hw/instr_extract.sv
hw/ifu_aligner.sv
testbench/tb_ifu_aligner.sv

// File: Makefile
# Verilator build and run of the fetch aligner testbench

TOP := tb_ifu_aligner

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// File: testbench/tb_fetch_model.svh
// fetch source with entry credit counting and the parcel reference queue, included by the testbench
`ifndef TB_FETCH_MODEL_SVH
`define TB_FETCH_MODEL_SVH

// one instruction parcel as the reference sees it
typedef struct packed {
   logic [HALF_W-1:0]  data;
   logic [PC_W-1:0]    pc;
   logic               icaf;
   logic               dbecc;
   fault_type_t        ftype;
} parcel_t;

parcel_t  ref_q[$];                       // parcels sent and not yet taken by decode
int       in_flight;                      // buffer entries fetch believes are used

// send one fetch word once an entry is free, caller sits at a falling edge
task automatic send_word(input parcel_t lo, input parcel_t hi, input logic two,
                         input fault_type_t ft);
   while (in_flight >= 3) @(negedge clk);
   fetch.data.parcel[0] = lo.data;
   fetch.data.parcel[1] = two ? hi.data : HALF_W'($urandom);
   fetch.pc             = lo.pc;
   fetch.val            = two ? 2'b11 : 2'b01;
   fetch.icaf           = {two & hi.icaf, lo.icaf};
   fetch.dbecc          = {two & hi.dbecc, lo.dbecc};
   fetch.icaf_type      = ft;
   lo.ftype = ft;
   ref_q.push_back(lo);
   if (two) begin
      hi.ftype = ft;
      ref_q.push_back(hi);
   end
   words_sent   = words_sent + 1;
   parcels_sent = parcels_sent + (two ? 2 : 1);
   @(negedge clk);
   fetch.val = 2'b00;
endtask

`endif

// File: testbench/tb_ifu_aligner.sv
// testbench of the fetch aligner; random fetch streams checked against a parcel reference queue
`default_nettype none
`timescale 1ns/1ps

module tb_ifu_aligner
   import aligner_pkg::*;
();

   logic        clk, reset, flush, async_error_start, decode;
   fetch_pkt_t  fetch;
   i0_pkt_t     i0;
   logic        consume1, consume2, instr_aligned;

   int          decode_pct;               // chance of a decode strobe per cycle
   int          words_sent, parcels_sent, entries_freed;
   int          cycles, errors, tests_pass, tests_fail;
   logic        stall_exp;                // error stall as the testbench expects it
   logic [PC_W-1:0]  next_pc;

   `include "tb_fetch_model.svh"

   parcel_t     pend[$];                  // parcels waiting to be packed into words

   ifu_aligner i_dut (
      .clk                (clk),
      .reset              (reset),
      .flush              (flush),
      .async_error_start  (async_error_start),
      .decode             (decode),
      .fetch              (fetch),
      .i0                 (i0),
      .consume1           (consume1),
      .consume2           (consume2),
      .instr_aligned      (instr_aligned)
   );

   always #2 clk = ~clk;

   always @(negedge clk) begin
      decode <= (int'($urandom % 100) < decode_pct);
   end

   // ************************************************************
   // assertions
   // ************************************************************
   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
      assert (exp == got) else begin
         $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
         errors++;
      end
   endtask

   a_hold: assert property (@(posedge clk) disable iff (reset)
      (i0.valid && !decode && !flush) |=> $stable(i0))
      else begin
         $display("i0 changed at %0t while decode was idle", $time);
         errors++;
      end
   a_idle: assert property (@(posedge clk) disable iff (reset)
      !decode |-> (!consume1 && !consume2))
      else begin
         $display("consume pulse without decode at %0t", $time);
         errors++;
      end
   a_flush_cons: assert property (@(posedge clk) disable iff (reset)
      flush |-> (!consume1 && !consume2))
      else begin
         $display("consume pulse in a flush cycle at %0t", $time);
         errors++;
      end
   a_flush_valid: assert property (@(posedge clk) disable iff (reset)
      flush |=> !i0.valid)
      else begin
         $display("i0 still valid after flush at %0t", $time);
         errors++;
      end
   a_stall: assert property (@(posedge clk) disable iff (reset)
      stall_exp |-> !instr_aligned)
      else begin
         $display("instruction aligned during error stall at %0t", $time);
         errors++;
      end
   a_shift: assert property (@(posedge clk) disable iff (reset)
      instr_aligned == (i0.valid && decode && !stall_exp))
      else begin
         $display("instr_aligned does not match the strobe at %0t", $time);
         errors++;
      end

   // reference compare on every instruction taken
   always @(posedge clk) begin
      parcel_t  p0, p1;
      logic     four, f0bad;
      if (!reset) begin
         entries_freed += int'(consume1) + 2 * int'(consume2);
         in_flight = in_flight + int'(fetch.val[0]) - int'(consume1) - 2 * int'(consume2);
         if (flush) begin
            ref_q.delete();
            in_flight = 0;
         end else if (i0.valid && decode && !stall_exp) begin
            p0   = ref_q.size() > 0 ? ref_q[0] : '0;
            four = (p0.data[1:0] == 2'b11);
            p1   = ref_q.size() > 1 ? ref_q[1] : '0;
            assert (ref_q.size() >= (four ? 2 : 1)) else begin
               $display("instruction taken at %0t with no parcels left to match", $time);
               errors++;
            end
            f0bad = p0.icaf | p0.dbecc;
            check_val("i0.instr", four ? {p1.data, p0.data} : {16'h0, p0.data}, i0.instr);
            check_val("i0.cinst", 32'(p0.data), 32'(i0.cinst));
            check_val("i0.pc", 32'(p0.pc), 32'(i0.pc));
            check_val("i0.pc4", 32'(four), 32'(i0.pc4));
            check_val("i0.icaf", 32'(p0.icaf | (four & p1.icaf)), 32'(i0.icaf));
            check_val("i0.dbecc", 32'(p0.dbecc | (four & p1.dbecc)), 32'(i0.dbecc));
            check_val("i0.icaf_second", 32'(four & ~f0bad & (p1.icaf | p1.dbecc)),
                      32'(i0.icaf_second));
            check_val("i0.icaf_type", 32'((four & ~f0bad) ? p1.ftype : p0.ftype),
                      32'(i0.icaf_type));
            if (ref_q.size() > 0) void'(ref_q.pop_front());
            if (four && ref_q.size() > 0) void'(ref_q.pop_front());
         end
         if (flush) stall_exp <= 1'b0;
         else if (async_error_start) stall_exp <= 1'b1;
      end
   end

   // run limit grows with the traffic
   always @(posedge clk) begin
      cycles++;
      if (cycles > 20 * parcels_sent + 200) begin
         $display("run stopped after %0d cycles without finishing", cycles);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   // ************************************************************
   // stimulus helpers
   // ************************************************************
   task automatic gen_stream(input int n, input int p4, input int pfault);
      parcel_t p;
      for (int i = 0; i < n; i++) begin
         p = '0;
         p.data = HALF_W'($urandom);
         if (int'($urandom % 100) < p4) begin
            p.data[1:0] = 2'b11;                // 4-byte instr with a second parcel after it
            p.pc = next_pc;
            p.icaf = (int'($urandom % 100) < pfault);
            p.dbecc = (int'($urandom % 100) < pfault);
            pend.push_back(p);
            next_pc = next_pc + PC_W'(1);
            p.data = HALF_W'($urandom);
         end else if (p.data[1:0] == 2'b11) begin
            p.data[1:0] = 2'b01;
         end
         p.pc = next_pc;
         p.icaf = (int'($urandom % 100) < pfault);
         p.dbecc = (int'($urandom % 100) < pfault);
         pend.push_back(p);
         next_pc = next_pc + PC_W'(1);
      end
   endtask

   task automatic send_pend(input int single_pct);
      parcel_t lo, hi;
      logic two;
      while (pend.size() > 0) begin
         lo  = pend.pop_front();
         two = (pend.size() > 0) && (int'($urandom % 100) >= single_pct);
         hi  = two ? pend.pop_front() : '0;
         send_word(lo, hi, two, fault_type_t'($urandom));
      end
   endtask

   task automatic drain();
      while (ref_q.size() > 0 || in_flight > 0) @(negedge clk);
   endtask

   task automatic end_test(input string name, input int err_start);
      if (errors == err_start) begin
         $display("test %s: ok", name);
         tests_pass++;
      end else begin
         $display("test %s: failed", name);
         tests_fail++;
      end
   endtask

   // ************************************************************
   // test sequence
   // ************************************************************
   initial begin
      int e0, w0, c0;
      void'($urandom(93895));
      clk = 1'b0;
      reset = 1'b1;
      flush = 1'b0;
      async_error_start = 1'b0;
      fetch = '0;
      decode = 1'b0;
      decode_pct = 0;
      stall_exp = 1'b0;
      in_flight = 0;
      words_sent = 0;
      parcels_sent = 0;
      entries_freed = 0;
      cycles = 0;
      errors = 0;
      tests_pass = 0;
      tests_fail = 0;
      repeat (10) @(posedge clk);
      @(negedge clk) reset = 1'b0;

      e0 = errors;
      w0 = words_sent;
      c0 = entries_freed;
      decode_pct = 60;
      next_pc = PC_W'($urandom);
      gen_stream(40, 100, 0);
      send_pend(0);
      drain();
      assert (entries_freed - c0 == words_sent - w0) else begin
         $display("consume pulses freed %0d entries for %0d words",
                  entries_freed - c0, words_sent - w0);
         errors++;
      end
      end_test("aligned 4-byte stream", e0);

      e0 = errors;
      gen_stream(60, 50, 0);
      send_pend(30);
      drain();
      end_test("mixed sizes", e0);

      e0 = errors;
      gen_stream(60, 50, 25);
      send_pend(30);
      drain();
      end_test("fault merging", e0);

      e0 = errors;
      decode_pct = 0;
      gen_stream(30, 50, 10);
      fork
         send_pend(30);
         begin
            repeat (30) @(negedge clk);
            decode_pct = 70;
         end
      join
      drain();
      end_test("back-pressure", e0);

      e0 = errors;
      decode_pct = 100;
      gen_stream(3, 100, 0);
      send_pend(0);
      flush = 1'b1;                                 // decode takes the last word in this cycle
      @(negedge clk) flush = 1'b0;
      decode_pct = 0;
      gen_stream(3, 100, 0);
      send_pend(0);
      async_error_start = 1'b1;
      @(negedge clk) async_error_start = 1'b0;
      decode_pct = 100;
      repeat (20) @(negedge clk);
      flush = 1'b1;
      @(negedge clk) flush = 1'b0;
      decode_pct = 60;
      next_pc = PC_W'($urandom);                    // fresh stream after flush
      gen_stream(20, 50, 0);
      send_pend(30);
      drain();
      end_test("flush and error stall", e0);

      $display("tests passed %0d failed %0d errors %0d", tests_pass, tests_fail, errors);
      if (errors == 0 && tests_fail == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: hw/ifu_aligner.sv
// top of the fetch aligner; connects the fetch buffer, the alignment control and the extractor
`default_nettype none
`timescale 1ns/1ps

module ifu_aligner
   import aligner_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        flush,
   input  logic        async_error_start,
   input  logic        decode,
   input  fetch_pkt_t  fetch,
   output i0_pkt_t     i0,
   output logic        consume1,
   output logic        consume2,
   output logic        instr_aligned
);

   window_t  window;                      // oldest two entries
   hval_t    f0val, f1val;
   logic     first4b;
   logic     f0_shift_2b, f1_shift_2b;

   // **********************************************************
   // buffer
   // **********************************************************
   fetch_queue u_fetch_queue (
      .clk          (clk),
      .reset        (reset),
      .flush        (flush),
      .fetch        (fetch),
      .consume1     (consume1),
      .consume2     (consume2),
      .f0_shift_2b  (f0_shift_2b),
      .f1_shift_2b  (f1_shift_2b),
      .window       (window)
   );

   // **********************************************************
   // bookkeeping
   // **********************************************************
   align_ctl u_align_ctl (
      .clk                (clk),
      .reset              (reset),
      .flush              (flush),
      .async_error_start  (async_error_start),
      .decode             (decode),
      .fetch_val          (fetch.val),
      .first4b            (first4b),
      .f0val              (f0val),
      .f1val              (f1val),
      .f0_shift_2b        (f0_shift_2b),
      .f1_shift_2b        (f1_shift_2b),
      .consume1           (consume1),
      .consume2           (consume2),
      .instr_aligned      (instr_aligned)
   );

   // decode side
   instr_extract u_instr_extract (
      .window   (window),
      .f0val    (f0val),
      .f1val    (f1val),
      .first4b  (first4b),
      .i0       (i0)
   );

endmodule

`default_nettype wire

// File: hw/instr_extract.sv
// aligner output stage; builds the decode instruction, its pc and merged fault flags
`default_nettype none
`timescale 1ns/1ps

module instr_extract
   import aligner_pkg::*;
(
   input  window_t  window,
   input  hval_t    f0val,
   input  hval_t    f1val,
   output logic     first4b,
   output i0_pkt_t  i0
);

   fetch_word_u  align_word;
   hval_t        alignval;                // parcels present for the aligned word
   logic [1:0]   alignicaf;
   logic [1:0]   aligndbecc;
   logic [1:0]   fault_eff;
   logic         from_f1;                 // upper parcel comes out of f1
   logic         ends_f1;

   // **********************************************************
   // parcel selection
   // **********************************************************
   assign from_f1 = ~f0val[1] & f0val[0];

   always_comb begin
      align_word.parcel[0] = window.f0.data.parcel[0];
      align_word.parcel[1] = from_f1 ? window.f1.data.parcel[0] : window.f0.data.parcel[1];
   end

   assign alignval   = f0val[1] ? 2'b11 : (f0val[0] ? {f1val[0], 1'b1} : 2'b00);
   assign alignicaf  = from_f1 ? {window.f1.icaf[0], window.f0.icaf[0]} : window.f0.icaf;
   assign aligndbecc = from_f1 ? {window.f1.dbecc[0], window.f0.dbecc[0]} : window.f0.dbecc;

   assign first4b = (align_word.parcel[0][1:0] == 2'b11);
   assign ends_f1 = first4b & from_f1;

   // **********************************************************
   // instruction to decode
   // **********************************************************
   assign fault_eff = alignicaf | aligndbecc;

   always_comb begin
      i0.valid = first4b ? alignval[1] : alignval[0];
      i0.instr = '0;
      if (first4b & alignval[1]) begin
         i0.instr = align_word.word;
      end else if (~first4b & alignval[0]) begin
         i0.instr = {{HALF_W{1'b0}}, align_word.parcel[0]};   // no expansion
      end
      i0.cinst = align_word.parcel[0];
      i0.pc    = window.f0.pc;
      i0.pc4   = first4b;

      // a fault on any parcel used marks the instruction
      i0.icaf  = first4b ? |alignicaf : alignicaf[0];
      i0.dbecc = first4b ? |aligndbecc : aligndbecc[0];

      i0.icaf_second = first4b & ~fault_eff[0] & fault_eff[1];

      // type of the faulting part of a straddling instr
      i0.icaf_type = (ends_f1 & ~alignicaf[0] & ~aligndbecc[0]) ?
                     window.f1.icaf_type : window.f0.icaf_type;
   end

endmodule

`default_nettype wire

// File: hw/align_ctl.sv
// aligner bookkeeping; tracks pending halfwords, decides shifts, consume pulses and error stall
`default_nettype none
`timescale 1ns/1ps

module align_ctl
   import aligner_pkg::*;
(
   input  logic   clk,
   input  logic   reset,
   input  logic   flush,
   input  logic   async_error_start,
   input  logic   decode,
   input  hval_t  fetch_val,
   input  logic   first4b,
   output hval_t  f0val,
   output hval_t  f1val,
   output logic   f0_shift_2b,
   output logic   f1_shift_2b,
   output logic   consume1,
   output logic   consume2,
   output logic   instr_aligned
);

   hval_t  f2val;
   hval_t  f0val_in, f1val_in, f2val_in;
   hval_t  sf0val, sf1val;                // valids after this cycle's shift
   logic   error_stall, error_stall_in;
   logic   ifvalid;
   logic   i0_avail, i0_shift;
   logic   shift_2b, shift_4b;
   logic   shift_f1_f0, shift_f2_f0, shift_f2_f1;
   logic   fetch_to_f0, fetch_to_f1, fetch_to_f2;
   logic   consume_f0, consume_f1;

   // **********************************************************
   // shift decision
   // **********************************************************
   assign error_stall_in = (error_stall | async_error_start) & ~flush;

   // every parcel of the presented instruction is here
   assign i0_avail = f0val[1] | (f0val[0] & (~first4b | f1val[0]));
   assign i0_shift = decode & i0_avail & ~error_stall;

   assign instr_aligned = i0_shift;
   assign shift_2b      = i0_shift & ~first4b;
   assign shift_4b      = i0_shift & first4b;

   // low parcel of f0 used, f1 low parcel used by a straddling 4-byte instr
   assign f0_shift_2b = (shift_2b & f0val[0]) | (shift_4b & f0val[0] & ~f0val[1]);
   assign f1_shift_2b = shift_4b & f0val[0] & ~f0val[1];

   assign sf0val = shift_4b ? 2'b00 :
                   shift_2b ? {1'b0, f0val[1]} : f0val;
   assign sf1val = f1_shift_2b ? {1'b0, f1val[1]} : f1val;

   // fetch side sees entries freed this cycle
   assign consume_f0 = f0val[0] & ~sf0val[0];
   assign consume_f1 = f1val[0] & ~sf1val[0];
   assign consume1   = consume_f0 & ~consume_f1 & ~flush;
   assign consume2   = consume_f0 & consume_f1 & ~flush;

   // **********************************************************
   // slot movement, { sf0, sf1, f2 } occupancy
   //   000 fetch->f0          100 fetch->f1
   //   010 fetch->f1, f1->f0  110 fetch->f2
   //   001 fetch->f1, f2->f0  011 fetch->f2, f2->f1, f1->f0
   //   111 no fetch           101 never reached
   // **********************************************************
   assign ifvalid     = fetch_val[0];
   assign shift_f1_f0 = ~sf0val[0] & sf1val[0];
   assign shift_f2_f0 = ~sf0val[0] & ~sf1val[0] & f2val[0];
   assign shift_f2_f1 = ~sf0val[0] & sf1val[0] & f2val[0];

   assign fetch_to_f0 = ifvalid & ~sf0val[0] & ~sf1val[0] & ~f2val[0];
   assign fetch_to_f1 = ifvalid & ((~sf0val[0] & ~sf1val[0] & f2val[0]) |
                                   (~sf0val[0] & sf1val[0] & ~f2val[0]) |
                                   (sf0val[0] & ~sf1val[0] & ~f2val[0]));
   assign fetch_to_f2 = ifvalid & ((~sf0val[0] & sf1val[0] & f2val[0]) |
                                   (sf0val[0] & sf1val[0] & ~f2val[0]));

   always_comb begin
      f0val_in = sf0val;
      f1val_in = sf1val;
      f2val_in = f2val;
      if (fetch_to_f0) begin
         f0val_in = fetch_val;
      end else if (shift_f2_f0) begin
         f0val_in = f2val;
      end else if (shift_f1_f0) begin
         f0val_in = sf1val;
      end
      if (fetch_to_f1) begin
         f1val_in = fetch_val;
      end else if (shift_f2_f1) begin
         f1val_in = f2val;
      end else if (shift_f1_f0) begin
         f1val_in = '0;
      end
      if (fetch_to_f2) begin
         f2val_in = fetch_val;
      end else if (shift_f2_f1 | shift_f2_f0) begin
         f2val_in = '0;
      end
      if (flush) begin                     // drop everything pending
         f0val_in = '0;
         f1val_in = '0;
         f2val_in = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         f0val       <= '0;
         f1val       <= '0;
         f2val       <= '0;
         error_stall <= 1'b0;
      end else begin
         f0val       <= f0val_in;
         f1val       <= f1val_in;
         f2val       <= f2val_in;
         error_stall <= error_stall_in;
      end
   end

endmodule

`default_nettype wire

// File: hw/fetch_queue.sv
// three-entry fetch buffer of the aligner; holds fetch words and presents the oldest two
`default_nettype none
`timescale 1ns/1ps

module fetch_queue
   import aligner_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        flush,
   input  fetch_pkt_t  fetch,
   input  logic        consume1,
   input  logic        consume2,
   input  logic        f0_shift_2b,
   input  logic        f1_shift_2b,
   output window_t     window
);

   q_entry_t    q [3];                    // entry payload
   q_entry_t    wr_entry;
   q_entry_t    f0eff, f1eff;             // entries rotated by the read pointer
   logic [1:0]  wrptr, wrptr_in;
   logic [1:0]  rdptr, rdptr_in;
   logic [1:0]  f1ptr;
   logic [2:0]  qoff, qoff_in;            // low parcel already used
   logic [2:0]  qwen;
   logic        f0off, f1off;
   logic        ifvalid;

   // advance a pointer, modulo 3
   function automatic logic [1:0] ptr_inc(input logic [1:0] ptr);
      return (ptr == 2'd2) ? 2'd0 : ptr + 2'd1;
   endfunction

   // drop the used low parcel and move the pc past it
   function automatic q_entry_t shift_entry(input q_entry_t e, input logic off);
      q_entry_t s;
      s = e;
      if (off) begin
         s.data.parcel[0] = e.data.parcel[1];
         s.data.parcel[1] = '0;
         s.icaf           = {1'b0, e.icaf[1]};
         s.dbecc          = {1'b0, e.dbecc[1]};
         s.pc             = e.pc + PC_W'(1);
      end
      return s;
   endfunction

   // **********************************************************
   // write side
   // **********************************************************
   assign ifvalid = fetch.val[0] & ~flush;   // nothing lands in a flush cycle
   assign f1ptr   = ptr_inc(rdptr);

   always_comb begin
      wr_entry.data      = fetch.data;
      wr_entry.pc        = fetch.pc;
      wr_entry.icaf      = fetch.icaf;
      wr_entry.dbecc     = fetch.dbecc;
      wr_entry.icaf_type = fetch.icaf_type;
      for (int i = 0; i < 3; i++) begin
         qwen[i] = ifvalid & (wrptr == 2'(i));
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < 3; i++) begin
         if (qwen[i]) begin
            q[i] <= wr_entry;
         end
      end
   end

   // **********************************************************
   // pointers and offsets
   // **********************************************************
   always_comb begin
      wrptr_in = wrptr;
      rdptr_in = rdptr;
      if (ifvalid) begin
         wrptr_in = ptr_inc(wrptr);
      end
      if (consume1) begin
         rdptr_in = ptr_inc(rdptr);
      end else if (consume2) begin
         rdptr_in = ptr_inc(ptr_inc(rdptr));
      end
      if (flush) begin
         wrptr_in = '0;
         rdptr_in = '0;
      end
   end

   always_comb begin
      for (int i = 0; i < 3; i++) begin
         qoff_in[i] = qoff[i];
         if (rdptr == 2'(i)) begin
            qoff_in[i] = qoff[i] | f0_shift_2b;     // entry is f0
         end else if (f1ptr == 2'(i)) begin
            qoff_in[i] = qoff[i] | f1_shift_2b;     // entry is f1
         end
         if (qwen[i] | flush) begin
            qoff_in[i] = 1'b0;                      // fresh word starts at low parcel
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wrptr <= '0;
         rdptr <= '0;
         qoff  <= '0;
      end else begin
         wrptr <= wrptr_in;
         rdptr <= rdptr_in;
         qoff  <= qoff_in;
      end
   end

   // **********************************************************
   // read window
   // **********************************************************
   always_comb begin
      case (rdptr)
         2'd1: begin
            f0eff = q[1];
            f1eff = q[2];
            f0off = qoff[1];
            f1off = qoff[2];
         end
         2'd2: begin
            f0eff = q[2];
            f1eff = q[0];
            f0off = qoff[2];
            f1off = qoff[0];
         end
         default: begin
            f0eff = q[0];
            f1eff = q[1];
            f0off = qoff[0];
            f1off = qoff[1];
         end
      endcase
   end

   assign window.f0 = shift_entry(f0eff, f0off);
   assign window.f1 = shift_entry(f1eff, f1off);

endmodule

`default_nettype wire

// File: hw/aligner_pkg.sv
// shared types and widths of the fetch aligner, imported by the RTL blocks and the testbench
`default_nettype none

package aligner_pkg;

   // **********************************************************
   // widths fixed by the instruction set
   // **********************************************************
   localparam int HALF_W = 16;            // one instruction parcel
   localparam int PC_W   = 31;            // pc bits 31:1

   // one fetch word, seen whole or as two parcels
   typedef union packed {
      logic [2*HALF_W-1:0]     word;
      logic [1:0][HALF_W-1:0]  parcel;    // [0] low, [1] high
   } fetch_word_u;

   typedef logic [1:0] fault_type_t;      // access fault type code
   typedef logic [1:0] hval_t;            // halfword valids, right justified

   // what fetch delivers in one cycle
   typedef struct packed {
      fetch_word_u      data;
      logic [PC_W-1:0]  pc;               // pc of the low parcel
      hval_t            val;              // 01 low only, 11 both
      logic [1:0]       icaf;             // access fault per parcel
      logic [1:0]       dbecc;            // double ecc per parcel
      fault_type_t      icaf_type;
   } fetch_pkt_t;

   // one buffer entry as the read window shows it
   typedef struct packed {
      fetch_word_u      data;
      logic [PC_W-1:0]  pc;
      logic [1:0]       icaf;
      logic [1:0]       dbecc;
      fault_type_t      icaf_type;
   } q_entry_t;

   // oldest two entries, next pending parcel already in the low half
   typedef struct packed {
      q_entry_t  f1;
      q_entry_t  f0;
   } window_t;

   // aligned instruction handed to decode
   typedef struct packed {
      logic                valid;
      logic [31:0]         instr;         // 2-byte instr zero extended
      logic [HALF_W-1:0]   cinst;         // raw low parcel
      logic [PC_W-1:0]     pc;
      logic                pc4;           // 4-byte instr
      logic                icaf;
      fault_type_t         icaf_type;
      logic                icaf_second;   // fault only on the upper half
      logic                dbecc;
   } i0_pkt_t;

endpackage

`default_nettype wire
